/* logic/cache_consts.svh */
`ifndef CACHE_CONSTS_SVH
`define CACHE_CONSTS_SVH

// physical address split into tag, index and offset
`define CACHE_TAG_W     20
`define CACHE_INDEX_W   8
`define CACHE_OFFSET_W  4

// data path widths
`define CACHE_WORD_W    32
`define CACHE_WORDS     4
`define CACHE_LINE_W    128

// one strobe bit per byte of a word
`define CACHE_STRB_W    4

// sets per way
`define CACHE_SETS      256

`endif

/* logic/cache_pkg.sv */
package cache_pkg;

    `include "cache_consts.svh"

    // address fields
    typedef logic [`CACHE_TAG_W-1:0]    tag_t;
    typedef logic [`CACHE_INDEX_W-1:0]  index_t;
    typedef logic [`CACHE_OFFSET_W-1:0] offset_t;

    // data
    typedef logic [`CACHE_WORD_W-1:0]   word_t;
    typedef logic [`CACHE_LINE_W-1:0]   line_t;
    typedef logic [`CACHE_STRB_W-1:0]   strb_t;

    typedef logic [$clog2(`CACHE_WORDS)-1:0] word_sel_t;
    typedef logic way_t;

    // main controller states
    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        STORE,
        WRITEBACK,
        REFILL_REQ,
        REFILL,
        REREAD
    } cache_state_t;

endpackage

/* logic/refill_beat_counter.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module refill_beat_counter
    import cache_pkg::*;
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    refill_active,
    input  logic                    ret_valid,
    input  logic                    ret_last,
    output logic [`CACHE_WORDS-1:0] refill_bank_we,
    output logic                    refill_done
);

    word_sel_t beat;
    logic      take;

    assign take = refill_active && ret_valid;

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            beat <= '0;
        end
        else if (take)
        begin
            // restart for the next line once the last word is in
            beat <= ret_last ? '0 : beat + 1'b1;
        end
    end

    assign refill_bank_we = take ? (`CACHE_WORDS'(1) << beat) : '0;
    assign refill_done    = take && ret_last;

endmodule

/* logic/tag_array.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module tag_array
    import cache_pkg::*;
(
    input  logic   clk,
    input  logic   resetn,
    input  index_t array_index,
    input  tag_t   req_tag,
    input  way_t   access_way,
    input  logic   store_en,
    input  logic   refill_done,
    output logic   hit,
    output way_t   hit_way,
    output way_t   victim_way,
    output logic   victim_dirty,
    output tag_t   victim_tag
);

    // valid, dirty and victim pointer per set
    logic [`CACHE_SETS-1:0] valid_bits [2];
    logic [`CACHE_SETS-1:0] dirty_bits [2];
    logic [`CACHE_SETS-1:0] victim_ptr;

    logic valid_q [2];
    tag_t tag_q   [2];
    logic way_hit [2];

    for (genvar w = 0; w < 2; w++)
    begin : g_way
        tag_t tag_mem [`CACHE_SETS];
        tag_t tag_rd;

        always_ff @(posedge clk)
        begin
            if (refill_done && access_way == way_t'(w))
            begin
                tag_mem[array_index] <= req_tag;
            end
            tag_rd <= tag_mem[array_index];
        end

        assign tag_q[w]   = tag_rd;
        assign way_hit[w] = valid_q[w] && (tag_q[w] == req_tag);
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            valid_bits[0] <= '0;
            valid_bits[1] <= '0;
            dirty_bits[0] <= '0;
            dirty_bits[1] <= '0;
            victim_ptr    <= '0;
            valid_q[0]    <= 1'b0;
            valid_q[1]    <= 1'b0;
        end
        else
        begin
            valid_q[0] <= valid_bits[0][array_index];
            valid_q[1] <= valid_bits[1][array_index];
            if (store_en)
            begin
                dirty_bits[access_way][array_index] <= 1'b1;
            end
            // new line is clean; other way becomes the next victim
            if (refill_done)
            begin
                valid_bits[access_way][array_index] <= 1'b1;
                dirty_bits[access_way][array_index] <= 1'b0;
                victim_ptr[array_index]             <= ~victim_ptr[array_index];
            end
        end
    end

    assign hit        = way_hit[0] || way_hit[1];
    assign hit_way    = way_hit[1];
    assign victim_way = victim_ptr[array_index];

    assign victim_dirty = valid_q[victim_way] && dirty_bits[victim_way][array_index];
    assign victim_tag   = tag_q[access_way];

endmodule

/* logic/data_array.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module data_array
    import cache_pkg::*;
(
    input  logic                    clk,
    input  index_t                  array_index,
    input  way_t                    access_way,
    input  word_sel_t               word_sel,
    input  logic                    store_en,
    input  strb_t                   store_wstrb,
    input  word_t                   store_wdata,
    input  logic [`CACHE_WORDS-1:0] refill_bank_we,
    input  word_t                   ret_data,
    output word_t                   rdata,
    output line_t                   victim_line
);

    word_t rd_word [2][`CACHE_WORDS];

    // one bank per word of the line in each way
    for (genvar w = 0; w < 2; w++)
    begin : g_way
        for (genvar b = 0; b < `CACHE_WORDS; b++)
        begin : g_bank
            word_t mem [`CACHE_SETS];
            word_t rd_q;
            logic  way_sel;

            assign way_sel = (access_way == way_t'(w));

            always_ff @(posedge clk)
            begin
                if (way_sel && refill_bank_we[b])
                begin
                    mem[array_index] <= ret_data;
                end
                else if (way_sel && store_en && word_sel == word_sel_t'(b))
                begin
                    for (int i = 0; i < `CACHE_STRB_W; i++)
                    begin
                        if (store_wstrb[i])
                        begin
                            mem[array_index][i*8 +: 8] <= store_wdata[i*8 +: 8];
                        end
                    end
                end
                rd_q <= mem[array_index];
            end

            assign rd_word[w][b] = rd_q;
        end
    end

    assign rdata = rd_word[access_way][word_sel];

    // whole line of the selected way with word 0 in the low bits
    always_comb
    begin
        for (int b = 0; b < `CACHE_WORDS; b++)
        begin
            victim_line[b*`CACHE_WORD_W +: `CACHE_WORD_W] = rd_word[access_way][b];
        end
    end

endmodule

/* logic/cache_ctrl.sv */
`timescale 1ns/1ps

module cache_ctrl
    import cache_pkg::*;
(
    input  logic      clk,
    input  logic      resetn,
    input  logic      valid,
    input  logic      op,
    input  index_t    index,
    input  tag_t      tag,
    input  offset_t   offset,
    input  strb_t     wstrb,
    input  word_t     wdata,
    input  logic      hit,
    input  way_t      hit_way,
    input  way_t      victim_way,
    input  logic      victim_dirty,
    input  logic      rd_rdy,
    input  logic      wr_rdy,
    input  logic      refill_done,
    output logic      addr_ok,
    output logic      data_ok,
    output logic      rd_req,
    output logic      wr_req,
    output index_t    array_index,
    output tag_t      req_tag,
    output word_sel_t word_sel,
    output way_t      access_way,
    output logic      store_en,
    output strb_t     store_wstrb,
    output word_t     store_wdata,
    output logic      refill_active
);

    cache_state_t state;
    cache_state_t state_next;

    // request buffer
    logic    buf_op;
    index_t  buf_index;
    tag_t    buf_tag;
    offset_t buf_offset;
    strb_t   buf_wstrb;
    word_t   buf_wdata;

    // way picked at lookup and kept until the request finishes
    way_t    way_q;

    logic    accept;

    assign accept = (state == IDLE) && valid;

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= state_next;
        end
    end

    always_comb
    begin
        state_next = state;
        case (state)
            IDLE:
            begin
                if (valid)
                begin
                    state_next = LOOKUP;
                end
            end
            LOOKUP:
            begin
                if (hit)
                begin
                    state_next = buf_op ? STORE : IDLE;
                end
                else
                begin
                    state_next = victim_dirty ? WRITEBACK : REFILL_REQ;
                end
            end
            STORE:
            begin
                state_next = IDLE;
            end
            WRITEBACK:
            begin
                if (wr_rdy)
                begin
                    state_next = REFILL_REQ;
                end
            end
            REFILL_REQ:
            begin
                if (rd_rdy)
                begin
                    state_next = REFILL;
                end
            end
            REFILL:
            begin
                if (refill_done)
                begin
                    state_next = REREAD;
                end
            end
            // arrays settle, then look up again
            REREAD:
            begin
                state_next = LOOKUP;
            end
            default:
            begin
                state_next = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (accept)
        begin
            buf_op     <= op;
            buf_index  <= index;
            buf_tag    <= tag;
            buf_offset <= offset;
            buf_wstrb  <= wstrb;
            buf_wdata  <= wdata;
        end
    end

    always_ff @(posedge clk)
    begin
        if (!resetn)
        begin
            way_q <= 1'b0;
        end
        else if (state == LOOKUP)
        begin
            way_q <= hit ? hit_way : victim_way;
        end
    end

    assign addr_ok       = (state == IDLE);
    assign data_ok       = ((state == LOOKUP) && hit && !buf_op) || (state == STORE);
    assign rd_req        = (state == REFILL_REQ);
    assign wr_req        = (state == WRITEBACK);
    assign refill_active = (state == REFILL);

    // arrays see the new index while idle so lookup has data one cycle later
    assign array_index = (state == IDLE) ? index : buf_index;
    assign req_tag     = buf_tag;
    assign word_sel    = word_sel_t'(buf_offset >> 2);
    assign access_way  = (state == LOOKUP) ? hit_way : way_q;

    assign store_en    = (state == STORE);
    assign store_wstrb = buf_wstrb;
    assign store_wdata = buf_wdata;

endmodule

/* logic/cache_top.sv */
`timescale 1ns/1ps
`include "cache_consts.svh"

module cache_top
    import cache_pkg::*;
(
    input  logic       clk,
    input  logic       resetn,
    // processor side
    input  logic       valid,
    input  logic       op,
    input  index_t     index,
    input  tag_t       tag,
    input  offset_t    offset,
    input  strb_t      wstrb,
    input  word_t      wdata,
    output logic       addr_ok,
    output logic       data_ok,
    output word_t      rdata,
    // memory read channel
    output logic       rd_req,
    output logic [31:0] rd_addr,
    input  logic       rd_rdy,
    input  logic       ret_valid,
    input  logic       ret_last,
    input  word_t      ret_data,
    // memory write channel
    output logic       wr_req,
    output logic [31:0] wr_addr,
    output line_t      wr_data,
    input  logic       wr_rdy
);

    index_t    array_index;
    tag_t      req_tag;
    tag_t      victim_tag;
    word_sel_t word_sel;
    way_t      access_way;
    way_t      hit_way;
    way_t      victim_way;
    logic      hit;
    logic      victim_dirty;
    logic      store_en;
    strb_t     store_wstrb;
    word_t     store_wdata;
    logic      refill_active;
    logic      refill_done;
    logic [`CACHE_WORDS-1:0] refill_bank_we;

    // line addresses are always aligned
    assign rd_addr = {req_tag, array_index, offset_t'(0)};
    assign wr_addr = {victim_tag, array_index, offset_t'(0)};

    cache_ctrl ctrl_i (
        .clk           (clk),
        .resetn        (resetn),
        .valid         (valid),
        .op            (op),
        .index         (index),
        .tag           (tag),
        .offset        (offset),
        .wstrb         (wstrb),
        .wdata         (wdata),
        .hit           (hit),
        .hit_way       (hit_way),
        .victim_way    (victim_way),
        .victim_dirty  (victim_dirty),
        .rd_rdy        (rd_rdy),
        .wr_rdy        (wr_rdy),
        .refill_done   (refill_done),
        .addr_ok       (addr_ok),
        .data_ok       (data_ok),
        .rd_req        (rd_req),
        .wr_req        (wr_req),
        .array_index   (array_index),
        .req_tag       (req_tag),
        .word_sel      (word_sel),
        .access_way    (access_way),
        .store_en      (store_en),
        .store_wstrb   (store_wstrb),
        .store_wdata   (store_wdata),
        .refill_active (refill_active)
    );

    refill_beat_counter beat_i (
        .clk            (clk),
        .resetn         (resetn),
        .refill_active  (refill_active),
        .ret_valid      (ret_valid),
        .ret_last       (ret_last),
        .refill_bank_we (refill_bank_we),
        .refill_done    (refill_done)
    );

    tag_array tags_i (
        .clk          (clk),
        .resetn       (resetn),
        .array_index  (array_index),
        .req_tag      (req_tag),
        .access_way   (access_way),
        .store_en     (store_en),
        .refill_done  (refill_done),
        .hit          (hit),
        .hit_way      (hit_way),
        .victim_way   (victim_way),
        .victim_dirty (victim_dirty),
        .victim_tag   (victim_tag)
    );

    data_array data_i (
        .clk            (clk),
        .array_index    (array_index),
        .access_way     (access_way),
        .word_sel       (word_sel),
        .store_en       (store_en),
        .store_wstrb    (store_wstrb),
        .store_wdata    (store_wdata),
        .refill_bank_we (refill_bank_we),
        .ret_data       (ret_data),
        .rdata          (rdata),
        .victim_line    (wr_data)
    );

endmodule

/* test/axi_mem_model.sv */
`timescale 1ns/1ps

module axi_mem_model
    import cache_pkg::*;
(
    input  logic        clk,
    input  logic        rd_req,
    input  logic [31:0] rd_addr,
    output logic        rd_rdy,
    output logic        ret_valid,
    output logic        ret_last,
    output word_t       ret_data,
    input  logic        wr_req,
    input  logic [31:0] wr_addr,
    input  line_t       wr_data,
    output logic        wr_rdy
);

    // word store for byte addresses below 64 KiB
    word_t       mem [16384];
    int          rd_count;
    int          wr_count;
    logic [31:0] last_rd_addr;
    logic [31:0] last_wr_addr;
    line_t       last_wr_line;

    initial
    begin
        int base;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        rd_count  = 0;
        wr_count  = 0;
        for (int i = 0; i < 16384; i++)
        begin
            mem[i] = (i * 4) ^ 32'h5a5a_0000;
        end
        forever
        begin
            @(posedge clk);
            if (wr_req)
            begin
                repeat ($urandom % 4) @(posedge clk);
                #1;
                wr_rdy = 1'b1;
                // request and line are taken at this edge
                @(posedge clk);
                base = wr_addr[15:2];
                for (int k = 0; k < 4; k++)
                begin
                    mem[base + k] = wr_data[k*32 +: 32];
                end
                last_wr_addr = wr_addr;
                last_wr_line = wr_data;
                wr_count++;
                #1;
                wr_rdy = 1'b0;
            end
            else if (rd_req)
            begin
                repeat ($urandom % 4) @(posedge clk);
                #1;
                rd_rdy = 1'b1;
                @(posedge clk);
                base = rd_addr[15:2];
                last_rd_addr = rd_addr;
                rd_count++;
                #1;
                rd_rdy = 1'b0;
                // four beats with random gaps in between
                for (int k = 0; k < 4; k++)
                begin
                    repeat ($urandom % 3)
                    begin
                        @(posedge clk);
                        #1;
                    end
                    ret_valid = 1'b1;
                    ret_last  = (k == 3);
                    ret_data  = mem[base + k];
                    @(posedge clk);
                    #1;
                    ret_valid = 1'b0;
                    ret_last  = 1'b0;
                end
            end
        end
    end

endmodule

/* test/cache_tb.sv */
`timescale 1ns/1ps

module cache_tb
    import cache_pkg::*;
();

    localparam int NUM_DIRECTED   = 11;
    localparam int NUM_ACCESSES   = 40;
    localparam int NUM_RANDOM     = NUM_ACCESSES - NUM_DIRECTED;
    localparam int TIMEOUT_CYCLES = NUM_ACCESSES * 200;

    logic        clk;
    logic        resetn;
    logic        valid;
    logic        op;
    index_t      index;
    tag_t        tag;
    offset_t     offset;
    strb_t       wstrb;
    word_t       wdata;
    logic        addr_ok;
    logic        data_ok;
    word_t       rdata;
    logic        rd_req;
    logic [31:0] rd_addr;
    logic        rd_rdy;
    logic        ret_valid;
    logic        ret_last;
    word_t       ret_data;
    logic        wr_req;
    logic [31:0] wr_addr;
    line_t       wr_data;
    logic        wr_rdy;

    int errors      = 0;
    int checks      = 0;
    int cycle_count = 0;

    // flat view of memory as the processor sees it
    word_t ref_mem [16384];

    cache_top dut_i (
        .clk       (clk),
        .resetn    (resetn),
        .valid     (valid),
        .op        (op),
        .index     (index),
        .tag       (tag),
        .offset    (offset),
        .wstrb     (wstrb),
        .wdata     (wdata),
        .addr_ok   (addr_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    axi_mem_model mem_i (
        .clk       (clk),
        .rd_req    (rd_req),
        .rd_addr   (rd_addr),
        .rd_rdy    (rd_rdy),
        .ret_valid (ret_valid),
        .ret_last  (ret_last),
        .ret_data  (ret_data),
        .wr_req    (wr_req),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_rdy    (wr_rdy)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES)
        begin
            $display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    function automatic logic [31:0] byte_addr(tag_t t, index_t ix, word_sel_t w);
        return {t, ix, w, 2'b00};
    endfunction

    function automatic int word_index(tag_t t, index_t ix, word_sel_t w);
        logic [31:0] a;
        a = byte_addr(t, ix, w);
        return int'(a[15:2]);
    endfunction

    function automatic line_t ref_line(tag_t t, index_t ix);
        line_t l;
        for (int k = 0; k < 4; k++)
        begin
            l[k*32 +: 32] = ref_mem[word_index(t, ix, word_sel_t'(k))];
        end
        return l;
    endfunction

    // inputs change 2 ns after the edge, outputs are read there too
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic check(input string what, input logic [127:0] got, input logic [127:0] exp);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("Mismatch at time %0t: %s got %0h expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic access(input logic is_store, input tag_t t, input index_t ix,
                          input word_sel_t w, input strb_t s, input word_t d,
                          output word_t rd, output int lat);
        valid  = 1'b1;
        op     = is_store;
        tag    = t;
        index  = ix;
        offset = {w, 2'b00};
        wstrb  = s;
        wdata  = d;
        while (!addr_ok)
        begin
            tick();
        end
        tick();
        valid = 1'b0;
        lat   = 1;
        while (!data_ok)
        begin
            tick();
            lat++;
        end
        rd = rdata;
        tick();
        check("addr_ok after data_ok", addr_ok, 1'b1);
        check("data_ok single pulse", data_ok, 1'b0);
    endtask

    task automatic load_check(input tag_t t, input index_t ix, input word_sel_t w,
                              input int exp_lat);
        word_t rd;
        int    lat;
        access(1'b0, t, ix, w, '0, '0, rd, lat);
        check($sformatf("load %0h/%0h/%0d", t, ix, w), rd, ref_mem[word_index(t, ix, w)]);
        if (exp_lat > 0)
        begin
            check("load hit latency", lat, exp_lat);
        end
    endtask

    task automatic store_word(input tag_t t, input index_t ix, input word_sel_t w,
                              input strb_t s, input word_t d, input int exp_lat);
        word_t rd;
        int    lat;
        int    a;
        access(1'b1, t, ix, w, s, d, rd, lat);
        a = word_index(t, ix, w);
        for (int i = 0; i < 4; i++)
        begin
            if (s[i])
            begin
                ref_mem[a][i*8 +: 8] = d[i*8 +: 8];
            end
        end
        if (exp_lat > 0)
        begin
            check("store hit latency", lat, exp_lat);
        end
    endtask

    task automatic reset_state();
        check("addr_ok after reset", addr_ok, 1'b1);
        check("data_ok after reset", data_ok, 1'b0);
        check("rd_req after reset", rd_req, 1'b0);
        check("wr_req after reset", wr_req, 1'b0);
    endtask

    task automatic load_miss_then_hit();
        int reads;
        reads = mem_i.rd_count;
        load_check(20'h1, 8'h10, 2'd1, 0);
        check("read requests on load miss", mem_i.rd_count, reads + 1);
        check("refill address", mem_i.last_rd_addr, byte_addr(20'h1, 8'h10, 2'd0));
        load_check(20'h1, 8'h10, 2'd3, 1);
        check("read requests on load hit", mem_i.rd_count, reads + 1);
    endtask

    task automatic store_hit_partial();
        store_word(20'h1, 8'h10, 2'd2, 4'b0101, 32'hdead_beef, 2);
        load_check(20'h1, 8'h10, 2'd2, 1);
    endtask

    task automatic store_miss_merge();
        int reads;
        reads = mem_i.rd_count;
        store_word(20'h2, 8'h20, 2'd0, 4'b1100, 32'h1234_5678, 0);
        check("read requests on store miss", mem_i.rd_count, reads + 1);
        load_check(20'h2, 8'h20, 2'd0, 1);
        load_check(20'h2, 8'h20, 2'd1, 1);
    endtask

    // set 0x30 fills way 0, way 1, then way 0 again and evicts the dirty line
    task automatic dirty_eviction();
        int    reads;
        int    writes;
        line_t dirty_line;
        store_word(20'h3, 8'h30, 2'd1, 4'b1111, 32'hcafe_f00d, 0);
        dirty_line = ref_line(20'h3, 8'h30);
        writes = mem_i.wr_count;
        load_check(20'h4, 8'h30, 2'd0, 0);
        load_check(20'h5, 8'h30, 2'd2, 0);
        check("write requests on eviction", mem_i.wr_count, writes + 1);
        check("write-back address", mem_i.last_wr_addr, byte_addr(20'h3, 8'h30, 2'd0));
        check("write-back line", mem_i.last_wr_line, dirty_line);
        reads = mem_i.rd_count;
        load_check(20'h3, 8'h30, 2'd1, 0);
        check("read requests on reload", mem_i.rd_count, reads + 1);
        check("write requests for clean victim", mem_i.wr_count, writes + 1);
    endtask

    task automatic random_traffic(input int count);
        tag_t      t;
        index_t    ix;
        word_sel_t w;
        strb_t     s;
        word_t     d;
        for (int n = 0; n < count; n++)
        begin
            t  = tag_t'(6 + $urandom % 6);
            ix = index_t'(8'h40 + $urandom % 4);
            w  = word_sel_t'($urandom % 4);
            if ($urandom % 2)
            begin
                s = strb_t'($urandom);
                d = $urandom;
                store_word(t, ix, w, s, d, 0);
            end
            else
            begin
                load_check(t, ix, w, 0);
            end
        end
    endtask

    initial
    begin
        void'($urandom(32'hcfb9_a83a));
        resetn = 1'b0;
        valid  = 1'b0;
        op     = 1'b0;
        index  = '0;
        tag    = '0;
        offset = '0;
        wstrb  = '0;
        wdata  = '0;
        // memory starts as byte address xor 5a5a_0000
        for (int i = 0; i < 16384; i++)
        begin
            ref_mem[i] = (i * 4) ^ 32'h5a5a_0000;
        end
        repeat (16) @(posedge clk);
        #2;
        resetn = 1'b1;

        reset_state();
        load_miss_then_hit();
        store_hit_partial();
        store_miss_merge();
        dirty_eviction();
        random_traffic(NUM_RANDOM);

        $display("checks: %0d errors: %0d reads: %0d writes: %0d",
                 checks, errors, mem_i.rd_count, mem_i.wr_count);
        if (errors == 0)
        begin
            $display("NO ERRORS");
        end
        else
        begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* verilog.f */
+incdir+logic
logic/cache_pkg.sv
logic/refill_beat_counter.sv
logic/tag_array.sv
logic/data_array.sv
logic/cache_ctrl.sv
logic/cache_top.sv
test/axi_mem_model.sv
test/cache_tb.sv
